// File: rtl/copro_cfg.svh
`ifndef COPRO_CFG_SVH
`define COPRO_CFG_SVH

// host mailbox window FEF8-FEFF, match on addr[15:3]
`define COPRO_TUBE_PAGE    13'h1FDF
// internal ram answers where addr[15:12] is one of these
`define COPRO_INT_LO_TOP   4'h0
`define COPRO_INT_HI_TOP   4'hF
// internal ram depth in words, indexed by addr[12:0]
`define COPRO_INT_WORDS    8192
// cycles per external byte cycle
`define COPRO_BYTE_WAIT    2
// external sram byte address width
`define COPRO_EXT_AW       17

`endif

// File: rtl/copro_bus_pkg.sv
package copro_bus_pkg;

   // ----------------------------------------
   // request target, set by the decode stage
   // ----------------------------------------
   typedef enum logic [1:0] {
      // word ram at 0000-0FFF and F000-FFFF
      REG_INT  = 2'd0,
      // byte-wide sram behind the controller
      REG_EXT  = 2'd1,
      // host mailbox at FEF8-FEFF
      REG_TUBE = 2'd2
   } region_e;

   // mailbox register select, addr[2:0]
   // offsets 3..7 are unused and read zero
   typedef enum logic [2:0] {
      MB_STATUS   = 3'd0,
      MB_H2P_DATA = 3'd1,
      MB_P2H_DATA = 3'd2
   } mbox_reg_e;

endpackage

// File: rtl/copro_mem_pkg.sv
package copro_mem_pkg;

   // ----------------------------------------
   // external sram controller
   // ----------------------------------------
   typedef enum logic [1:0] {
      // no transfer, sram deselected
      EXT_IDLE = 2'd0,
      // even byte cycle
      EXT_LO   = 2'd1,
      // odd byte cycle
      EXT_HI   = 2'd2
   } ext_state_e;

   // byte lane of the current cycle
   // also the sram address bit 0
   typedef enum logic {
      // even address, data bits 7:0
      LANE_LO = 1'b0,
      // odd address, data bits 15:8
      LANE_HI = 1'b1
   } byte_lane_e;

endpackage

// File: rtl/copro_stage_if.sv
`timescale 1ns/10ps

interface copro_stage_if;

   // one decoded cpu request
   logic                    valid;
   logic                    rnw;
   copro_bus_pkg::region_e  region;
   logic [15:0]             addr;
   logic [15:0]             wdata;
   // access stage busy, item stays in decode
   logic                    stall;

   // ----------------------------------------
   // decode side drives the request
   // ----------------------------------------
   modport decode (
      output valid, rnw, region, addr, wdata,
      input  stall
   );

   // access side consumes it, pushes back stall
   modport access (
      input  valid, rnw, region, addr, wdata,
      output stall
   );

endinterface

// File: rtl/int_word_ram.sv
`timescale 1ns/10ps
`include "copro_cfg.svh"

module int_word_ram (
   input  logic        cpu_clk,
   input  logic        en,
   input  logic        we,
   input  logic [12:0] index,
   input  logic [15:0] wdata,
   output logic [15:0] rdata
);

   // ----------------------------------------
   // word array, upper half holds F000-FFFF
   // ----------------------------------------
   logic [15:0] mem [0:`COPRO_INT_WORDS-1];

   // single port, write or read per cycle
   always_ff @(posedge cpu_clk)
   begin
      if (en)
      begin
         if (we)
            mem[index] <= wdata;
         // read word ready the cycle after
         else
            rdata <= mem[index];
      end
   end

endmodule

// File: rtl/host_mailbox.sv
`timescale 1ns/10ps

module host_mailbox (
   input  logic                     cpu_clk,
   input  logic                     rst_n,
   input  logic                     sel,
   input  logic                     rnw,
   input  copro_bus_pkg::mbox_reg_e reg_sel,
   input  logic [7:0]               wdata,
   input  logic                     h_wr,
   input  logic [7:0]               h_wdata,
   input  logic                     h_rd,
   output logic [7:0]               rdata,
   output logic [7:0]               h_rdata,
   output logic [1:0]               h_status,
   output logic                     irq_b
);

   logic       cpu_rd;
   logic       cpu_wr;
   logic       h2p_full;
   logic [7:0] h2p_data;
   logic       p2h_full;
   logic [7:0] p2h_data;

   assign cpu_rd = sel && rnw;
   assign cpu_wr = sel && !rnw;

   // ----------------------------------------
   // full flags
   // ----------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      if (!rst_n)
      begin
         h2p_full <= 1'b0;
         p2h_full <= 1'b0;
      end
      else
      begin
         // host write lands only in an empty slot
         if (h_wr && !h2p_full)
            h2p_full <= 1'b1;
         else if (cpu_rd && (reg_sel == copro_bus_pkg::MB_H2P_DATA))
            h2p_full <= 1'b0;
         // cpu side mirrors it
         if (cpu_wr && (reg_sel == copro_bus_pkg::MB_P2H_DATA) && !p2h_full)
            p2h_full <= 1'b1;
         else if (h_rd)
            p2h_full <= 1'b0;
      end
   end

   // data bytes, loaded with their flag
   always_ff @(posedge cpu_clk)
   begin
      if (h_wr && !h2p_full)
         h2p_data <= h_wdata;
      if (cpu_wr && (reg_sel == copro_bus_pkg::MB_P2H_DATA) && !p2h_full)
         p2h_data <= wdata;
   end

   // ----------------------------------------
   // cpu read port, one cycle return
   // ----------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      if (cpu_rd)
      begin
         case (reg_sel)
            copro_bus_pkg::MB_STATUS:   rdata <= {6'b0, p2h_full, h2p_full};
            copro_bus_pkg::MB_H2P_DATA: rdata <= h2p_data;
            copro_bus_pkg::MB_P2H_DATA: rdata <= p2h_data;
            // unused offsets
            default:                    rdata <= 8'h00;
         endcase
      end
   end

   // host side always sees the outbound byte
   assign h_rdata  = p2h_data;
   assign h_status = {p2h_full, h2p_full};
   // interrupt pending while inbound byte waits
   assign irq_b    = !h2p_full;

endmodule

// File: rtl/ext_mem_ctrl.sv
`timescale 1ns/10ps
`include "copro_cfg.svh"

module ext_mem_ctrl (
   input  logic                      cpu_clk,
   input  logic                      rst_n,
   input  logic                      start,
   input  logic                      rnw,
   input  logic [15:0]               addr,
   input  logic [15:0]               wdata,
   input  logic [7:0]                ram_rdata,
   output logic                      busy,
   output logic                      done,
   output logic [15:0]               rdata,
   output logic                      ram_cs_b,
   output logic                      ram_oe_b,
   output logic                      ram_we_b,
   output logic [`COPRO_EXT_AW-1:0]  ram_addr,
   output logic [7:0]                ram_wdata
);

   // wait counter width, at least one bit
   localparam int CW = (`COPRO_BYTE_WAIT > 1) ? $clog2(`COPRO_BYTE_WAIT) : 1;
   localparam logic [CW-1:0] LAST = CW'(`COPRO_BYTE_WAIT - 1);

   copro_mem_pkg::ext_state_e state;
   copro_mem_pkg::byte_lane_e lane;
   logic [CW-1:0]             cnt;
   logic                      lane_end;
   logic                      done_q;
   logic                      rnw_q;
   logic [15:0]               addr_q;
   logic [15:0]               wdata_q;
   logic [15:0]               rdata_q;

   assign busy     = (state != copro_mem_pkg::EXT_IDLE);
   assign lane_end = (cnt == LAST);
   assign lane     = (state == copro_mem_pkg::EXT_HI) ? copro_mem_pkg::LANE_HI
                                                      : copro_mem_pkg::LANE_LO;

   // ----------------------------------------
   // sequencer, lo lane then hi lane
   // ----------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      if (!rst_n)
      begin
         state  <= copro_mem_pkg::EXT_IDLE;
         cnt    <= '0;
         done_q <= 1'b0;
      end
      else
      begin
         done_q <= 1'b0;
         case (state)
            copro_mem_pkg::EXT_IDLE:
               if (start)
               begin
                  state <= copro_mem_pkg::EXT_LO;
                  cnt   <= '0;
               end
            copro_mem_pkg::EXT_LO:
               if (lane_end)
               begin
                  state <= copro_mem_pkg::EXT_HI;
                  cnt   <= '0;
               end
               else
                  cnt <= cnt + 1'b1;
            copro_mem_pkg::EXT_HI:
               if (lane_end)
               begin
                  state  <= copro_mem_pkg::EXT_IDLE;
                  cnt    <= '0;
                  // strobe only for reads, a write just ends
                  done_q <= rnw_q;
               end
               else
                  cnt <= cnt + 1'b1;
            default:
               state <= copro_mem_pkg::EXT_IDLE;
         endcase
      end
   end

   // request latched at start
   always_ff @(posedge cpu_clk)
   begin
      if (start && !busy)
      begin
         rnw_q   <= rnw;
         addr_q  <= addr;
         wdata_q <= wdata;
      end
      // byte sampled at the end of its lane
      if (busy && rnw_q && lane_end)
      begin
         if (lane == copro_mem_pkg::LANE_HI)
            rdata_q[15:8] <= ram_rdata;
         else
            rdata_q[7:0]  <= ram_rdata;
      end
   end

   // ----------------------------------------
   // sram pins
   // ----------------------------------------
   assign ram_cs_b  = !busy;
   assign ram_oe_b  = !(busy && rnw_q);
   // write pulse in the last cycle of each lane
   assign ram_we_b  = !(busy && !rnw_q && lane_end);
   // word address, lane as byte bit 0
   assign ram_addr  = {addr_q, lane};
   assign ram_wdata = (lane == copro_mem_pkg::LANE_HI) ? wdata_q[15:8] : wdata_q[7:0];

   assign done  = done_q;
   assign rdata = rdata_q;

endmodule

// File: rtl/addr_decode_stage.sv
`timescale 1ns/10ps
`include "copro_cfg.svh"

module addr_decode_stage (
   input  logic          cpu_clk,
   input  logic          rst_n,
   input  logic          mreq_b,
   input  logic          rnw,
   input  logic [15:0]   addr,
   input  logic [15:0]   wdata,
   input  logic          clken,
   copro_stage_if.decode out
);

   logic                   accept;
   copro_bus_pkg::region_e region_d;
   logic                   valid_q;
   logic                   rnw_q;
   copro_bus_pkg::region_e region_q;
   logic [15:0]            addr_q;
   logic [15:0]            wdata_q;

   // cpu request taken only while clken is high
   assign accept = !mreq_b && clken;

   // ----------------------------------------
   // region decode
   // ----------------------------------------
   // mailbox window overlays the top of internal ram
   always_comb
   begin
      if (addr[15:3] == `COPRO_TUBE_PAGE)
         region_d = copro_bus_pkg::REG_TUBE;
      else if ((addr[15:12] == `COPRO_INT_LO_TOP) || (addr[15:12] == `COPRO_INT_HI_TOP))
         region_d = copro_bus_pkg::REG_INT;
      else
         region_d = copro_bus_pkg::REG_EXT;
   end

   // valid only, payload follows it
   always_ff @(posedge cpu_clk)
   begin
      if (!rst_n)
         valid_q <= 1'b0;
      // stalled item stays put
      else if (!out.stall)
         valid_q <= accept;
   end

   always_ff @(posedge cpu_clk)
   begin
      if (!out.stall && accept)
      begin
         rnw_q    <= rnw;
         region_q <= region_d;
         addr_q   <= addr;
         wdata_q  <= wdata;
      end
   end

   assign out.valid  = valid_q;
   assign out.rnw    = rnw_q;
   assign out.region = region_q;
   assign out.addr   = addr_q;
   assign out.wdata  = wdata_q;

endmodule

// File: rtl/access_stage.sv
`timescale 1ns/10ps
`include "copro_cfg.svh"

module access_stage (
   input  logic                      cpu_clk,
   input  logic                      rst_n,
   input  logic                      h_wr,
   input  logic [7:0]                h_wdata,
   input  logic                      h_rd,
   input  logic [7:0]                ram_rdata,
   copro_stage_if.access             in,
   output logic [15:0]               rdata,
   output logic                      rd_stb,
   output logic                      clken,
   output logic                      irq_b,
   output logic [7:0]                h_rdata,
   output logic [1:0]                h_status,
   output logic                      ram_cs_b,
   output logic                      ram_oe_b,
   output logic                      ram_we_b,
   output logic [`COPRO_EXT_AW-1:0]  ram_addr,
   output logic [7:0]                ram_wdata
);

   logic                   move;
   logic                   int_en;
   logic                   tube_sel;
   logic                   ext_start;
   logic                   ext_busy;
   logic                   ext_done;
   logic [15:0]            int_rdata;
   logic [7:0]             mb_rdata;
   logic [15:0]            ext_rdata;
   logic                   stb_q;
   logic                   clken_q;
   copro_bus_pkg::region_e rsp_region;

   // item leaves decode this edge
   assign move      = in.valid && !in.stall;
   assign int_en    = move && (in.region == copro_bus_pkg::REG_INT);
   assign tube_sel  = move && (in.region == copro_bus_pkg::REG_TUBE);
   assign ext_start = move && (in.region == copro_bus_pkg::REG_EXT);

   // hold decode for the whole sram transfer
   assign in.stall = ext_busy;

   // ----------------------------------------
   // strobe, clken, return select
   // ----------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      if (!rst_n)
      begin
         stb_q      <= 1'b0;
         clken_q    <= 1'b1;
         rsp_region <= copro_bus_pkg::REG_INT;
      end
      else
      begin
         // fixed one-cycle return for ram and mailbox
         stb_q   <= (int_en || tube_sel) && in.rnw;
         // cpu held off from start until controller idles
         clken_q <= !(ext_start || ext_busy);
         if (move && in.rnw)
            rsp_region <= in.region;
      end
   end

   assign rd_stb = stb_q || ext_done;
   assign clken  = clken_q;

   // return mux follows the last read issued
   always_comb
   begin
      case (rsp_region)
         copro_bus_pkg::REG_INT:  rdata = int_rdata;
         copro_bus_pkg::REG_TUBE: rdata = {8'h00, mb_rdata};
         default:                 rdata = ext_rdata;
      endcase
   end

   // ----------------------------------------
   // targets
   // ----------------------------------------
   int_word_ram ram_i (
      .cpu_clk (cpu_clk),
      .en      (int_en),
      .we      (!in.rnw),
      .index   (in.addr[12:0]),
      .wdata   (in.wdata),
      .rdata   (int_rdata)
   );

   host_mailbox mbox_i (
      .cpu_clk  (cpu_clk),
      .rst_n    (rst_n),
      .sel      (tube_sel),
      .rnw      (in.rnw),
      .reg_sel  (copro_bus_pkg::mbox_reg_e'(in.addr[2:0])),
      .wdata    (in.wdata[7:0]),
      .h_wr     (h_wr),
      .h_wdata  (h_wdata),
      .h_rd     (h_rd),
      .rdata    (mb_rdata),
      .h_rdata  (h_rdata),
      .h_status (h_status),
      .irq_b    (irq_b)
   );

   ext_mem_ctrl ext_i (
      .cpu_clk   (cpu_clk),
      .rst_n     (rst_n),
      .start     (ext_start),
      .rnw       (in.rnw),
      .addr      (in.addr),
      .wdata     (in.wdata),
      .ram_rdata (ram_rdata),
      .busy      (ext_busy),
      .done      (ext_done),
      .rdata     (ext_rdata),
      .ram_cs_b  (ram_cs_b),
      .ram_oe_b  (ram_oe_b),
      .ram_we_b  (ram_we_b),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata)
   );

endmodule

// File: rtl/copro_bus.sv
`timescale 1ns/10ps
`include "copro_cfg.svh"

module copro_bus (
   input  logic                      cpu_clk,
   input  logic                      rst_n,
   // cpu bus
   input  logic                      mreq_b,
   input  logic                      rnw,
   input  logic [15:0]               addr,
   input  logic [15:0]               wdata,
   output logic [15:0]               rdata,
   output logic                      rd_stb,
   output logic                      clken,
   output logic                      irq_b,
   // host strobes
   input  logic                      h_wr,
   input  logic [7:0]                h_wdata,
   input  logic                      h_rd,
   output logic [7:0]                h_rdata,
   output logic [1:0]                h_status,
   // byte-wide sram
   input  logic [7:0]                ram_rdata,
   output logic                      ram_cs_b,
   output logic                      ram_oe_b,
   output logic                      ram_we_b,
   output logic [`COPRO_EXT_AW-1:0]  ram_addr,
   output logic [7:0]                ram_wdata
);

   // decode to access hand-off
   copro_stage_if stage_if ();

   // ----------------------------------------
   // stage 1
   // ----------------------------------------
   addr_decode_stage decode_i (
      .cpu_clk (cpu_clk),
      .rst_n   (rst_n),
      .mreq_b  (mreq_b),
      .rnw     (rnw),
      .addr    (addr),
      .wdata   (wdata),
      .clken   (clken),
      .out     (stage_if.decode)
   );

   // stage 2, also the clken source
   access_stage access_i (
      .cpu_clk   (cpu_clk),
      .rst_n     (rst_n),
      .h_wr      (h_wr),
      .h_wdata   (h_wdata),
      .h_rd      (h_rd),
      .ram_rdata (ram_rdata),
      .in        (stage_if.access),
      .rdata     (rdata),
      .rd_stb    (rd_stb),
      .clken     (clken),
      .irq_b     (irq_b),
      .h_rdata   (h_rdata),
      .h_status  (h_status),
      .ram_cs_b  (ram_cs_b),
      .ram_oe_b  (ram_oe_b),
      .ram_we_b  (ram_we_b),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata)
   );

endmodule

// File: tests/copro_props.sv
`timescale 1ns/10ps

module copro_props (
   input logic cpu_clk,
   input logic rst_n,
   input logic mreq_b,
   input logic rnw,
   input logic clken,
   input logic rd_stb,
   input logic ram_cs_b,
   input logic ram_oe_b,
   input logic ram_we_b
);

   // tally of failed properties, read by the testbench
   int fail_count = 0;
   int acc_reads;
   int stb_seen;

   // ----------------------------------------
   // accepted reads against strobes
   // ----------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      if (!rst_n)
      begin
         acc_reads <= 0;
         stb_seen  <= 0;
      end
      else
      begin
         if (!mreq_b && clken && rnw)
            acc_reads <= acc_reads + 1;
         if (rd_stb)
            stb_seen <= stb_seen + 1;
      end
   end

   // sram output enable and write never together
   oe_we_excl: assert property (@(posedge cpu_clk) disable iff (!rst_n)
      ram_oe_b || ram_we_b)
   else
   begin
      fail_count = fail_count + 1;
      $error("ram_oe_b and ram_we_b low together");
   end

   // strobes only inside a chip select
   stb_in_cs: assert property (@(posedge cpu_clk) disable iff (!rst_n)
      (!ram_oe_b || !ram_we_b) |-> !ram_cs_b)
   else
   begin
      fail_count = fail_count + 1;
      $error("sram strobe low with ram_cs_b high");
   end

   // reset value of clken seen on release
   clken_after_rst: assert property (@(posedge cpu_clk)
      $rose(rst_n) |-> clken)
   else
   begin
      fail_count = fail_count + 1;
      $error("clken low in the first cycle after reset");
   end

   // every strobe owed to an earlier accepted read
   one_stb_per_rd: assert property (@(posedge cpu_clk) disable iff (!rst_n)
      rd_stb |-> (stb_seen < acc_reads))
   else
   begin
      fail_count = fail_count + 1;
      $error("rd_stb without an outstanding read");
   end

endmodule

bind copro_bus copro_props props_i (
   .cpu_clk  (cpu_clk),
   .rst_n    (rst_n),
   .mreq_b   (mreq_b),
   .rnw      (rnw),
   .clken    (clken),
   .rd_stb   (rd_stb),
   .ram_cs_b (ram_cs_b),
   .ram_oe_b (ram_oe_b),
   .ram_we_b (ram_we_b)
);

// File: tests/copro_tb.sv
`timescale 1ns/10ps
`include "copro_cfg.svh"

module copro_tb;

   logic                      cpu_clk;
   logic                      rst_n;
   logic                      mreq_b;
   logic                      rnw;
   logic [15:0]               addr;
   logic [15:0]               wdata;
   logic [15:0]               rdata;
   logic                      rd_stb;
   logic                      clken;
   logic                      irq_b;
   logic                      h_wr;
   logic [7:0]                h_wdata;
   logic                      h_rd;
   logic [7:0]                h_rdata;
   logic [1:0]                h_status;
   logic [7:0]                ram_rdata;
   logic                      ram_cs_b;
   logic                      ram_oe_b;
   logic                      ram_we_b;
   logic [`COPRO_EXT_AW-1:0]  ram_addr;
   logic [7:0]                ram_wdata;

   // ----------------------------------------
   // models and scoreboard
   // ----------------------------------------
   logic [7:0]                sram [0:(1 << `COPRO_EXT_AW)-1];
   // word view of int and ext regions
   logic [15:0]               ref_mem [0:65535];
   logic                      written [0:65535];
   logic                      h2p_full;
   logic                      p2h_full;
   logic [7:0]                h2p_data;
   logic [7:0]                p2h_data;
   // expected read word and strobe edge with -1 meaning any edge
   logic [15:0]               exp_data_q [$];
   int                        exp_edge_q [$];
   logic [15:0]               ext_wr_q [$];
   logic [31:0]               lfsr;
   logic                      check_lat;
   int                        edge_cnt = 0;
   int                        budget = 40;
   int                        cs_run = 0;

   copro_bus dut_i (.*);

   initial
   begin
      cpu_clk = 1'b0;
      forever #10 cpu_clk = ~cpu_clk;
   end

   // sram reads combinational while selected and output enabled
   assign ram_rdata = (ram_cs_b === 1'b0 && ram_oe_b === 1'b0) ? sram[ram_addr] : 8'h00;

   always @(posedge cpu_clk)
   begin
      if (rst_n && !ram_cs_b && !ram_we_b)
         sram[ram_addr] <= ram_wdata;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp)
      else fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
   endtask

   // every address bit feeds the pattern
   function automatic logic [7:0] fill_byte(input logic [16:0] i);
      fill_byte = i[7:0] ^ i[15:8] ^ {i[16], 7'h35};
   endfunction

   // galois form of x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic coin();
      logic [31:0] r;
      r = rand_bits(1);
      return r[0];
   endfunction

   // 32 words in each internal window
   function automatic logic [15:0] int_addr();
      logic [31:0] r;
      r = rand_bits(6);
      return {r[5] ? 4'hF : 4'h0, 7'h00, r[4:0]};
   endfunction

   // top nibble 1..E from a small pool so reads hit earlier writes
   function automatic logic [15:0] ext_addr();
      logic [31:0] r;
      logic [3:0]  nib;
      r   = rand_bits(7);
      nib = (r[6:3] % 4'd14) + 4'd1;
      return {nib, 9'h000, r[2:0]};
   endfunction

   // region rules straight from the memory map
   function automatic copro_bus_pkg::region_e region_of(input logic [15:0] a);
      if ((a >= 16'hFEF8) && (a <= 16'hFEFF))
         return copro_bus_pkg::REG_TUBE;
      else if ((a < 16'h1000) || (a >= 16'hF000))
         return copro_bus_pkg::REG_INT;
      else
         return copro_bus_pkg::REG_EXT;
   endfunction

   // ----------------------------------------
   // cpu bus master
   // ----------------------------------------
   task automatic issue(input logic is_rd, input logic [15:0] a, input logic [15:0] d);
      logic [15:0]            exp;
      copro_bus_pkg::region_e rgn;
      rgn = region_of(a);
      exp = 16'h0000;
      @(negedge cpu_clk);
      mreq_b = 1'b0;
      rnw    = is_rd;
      addr   = a;
      wdata  = d;
      // request held until clken lets it in
      while (!clken)
         @(negedge cpu_clk);
      budget += 12;
      // model steps in acceptance order
      if (rgn == copro_bus_pkg::REG_TUBE)
      begin
         if (is_rd)
         begin
            case (a[2:0])
               3'd0: exp = {14'h0000, p2h_full, h2p_full};
               3'd1:
               begin
                  exp      = {8'h00, h2p_data};
                  h2p_full = 1'b0;
               end
               3'd2: exp = {8'h00, p2h_data};
               default: exp = 16'h0000;
            endcase
         end
         else if ((a[2:0] == 3'd2) && !p2h_full)
         begin
            p2h_full = 1'b1;
            p2h_data = d[7:0];
         end
      end
      else if (is_rd)
         exp = ref_mem[a];
      else
      begin
         ref_mem[a] = d;
         written[a] = 1'b1;
         if (rgn == copro_bus_pkg::REG_EXT)
            ext_wr_q.push_back(a);
      end
      if (is_rd)
      begin
         exp_data_q.push_back(exp);
         // accept edge is the next one and the strobe is seen one edge later
         if (check_lat && (rgn != copro_bus_pkg::REG_EXT))
            exp_edge_q.push_back(edge_cnt + 2);
         else
            exp_edge_q.push_back(-1);
      end
   endtask

   task automatic bus_idle();
      @(negedge cpu_clk);
      mreq_b = 1'b1;
      budget += 1;
   endtask

   // idle until no read outstanding and clken steady high
   task automatic drain();
      int stable;
      stable = 0;
      bus_idle();
      budget += 6;
      while (stable < 3)
      begin
         @(negedge cpu_clk);
         if ((exp_data_q.size() == 0) && clken)
            stable++;
         else
            stable = 0;
      end
   endtask

   task automatic host_write(input logic [7:0] b);
      @(negedge cpu_clk);
      h_wr    = 1'b1;
      h_wdata = b;
      @(negedge cpu_clk);
      h_wr = 1'b0;
      // dropped when already full
      if (!h2p_full)
      begin
         h2p_full = 1'b1;
         h2p_data = b;
      end
      budget += 4;
   endtask

   task automatic host_read();
      @(negedge cpu_clk);
      h_rd = 1'b1;
      @(negedge cpu_clk);
      h_rd     = 1'b0;
      p2h_full = 1'b0;
      budget += 4;
   endtask

   task automatic check_host_pins();
      check_val("h_status", {14'h0000, h_status}, {14'h0000, p2h_full, h2p_full});
      check_val("irq_b", {15'h0000, irq_b}, {15'h0000, !h2p_full});
      if (p2h_full)
      begin
         check_val("h_rdata", {8'h00, h_rdata}, {8'h00, p2h_data});
      end
   endtask

   // ----------------------------------------
   // monitors and watchdog
   // ----------------------------------------
   always @(posedge cpu_clk)
   begin
      edge_cnt = edge_cnt + 1;
      if (edge_cnt > 8 * budget)
         fail_run($sformatf("timeout after %0d cycles, bus stopped making progress", edge_cnt));
   end

   always @(negedge cpu_clk)
   begin : bus_monitor
      logic [15:0] exp_d;
      int          exp_e;
      if (rst_n === 1'b1)
      begin
         if (rd_stb)
         begin
            assert (exp_data_q.size() != 0)
            else fail_run("rd_stb pulsed with no read outstanding");
            exp_d = exp_data_q.pop_front();
            exp_e = exp_edge_q.pop_front();
            check_val("rdata", rdata, exp_d);
            assert ((exp_e < 0) || (edge_cnt == exp_e))
            else fail_run($sformatf("read strobe came at edge %0d instead of edge %0d",
                                    edge_cnt, exp_e));
         end
         // cpu stalled for the whole sram transfer
         assert (ram_cs_b || !clken)
         else fail_run("clken stayed high during an sram transfer");
         if (!ram_cs_b)
            cs_run = cs_run + 1;
         else if (cs_run != 0)
         begin
            check_val("ram_cs_b low cycles", 16'(cs_run), 16'(2 * `COPRO_BYTE_WAIT));
            cs_run = 0;
         end
      end
   end

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial
   begin : main
      logic [15:0] a;
      logic [31:0] r;
      logic        rd;
      mreq_b    = 1'b1;
      rnw       = 1'b1;
      addr      = 16'h0000;
      wdata     = 16'h0000;
      h_wr      = 1'b0;
      h_wdata   = 8'h00;
      h_rd      = 1'b0;
      rst_n     = 1'b0;
      check_lat = 1'b1;
      lfsr      = 32'h003c_3b05;
      h2p_full  = 1'b0;
      p2h_full  = 1'b0;
      h2p_data  = 8'h00;
      p2h_data  = 8'h00;
      for (int i = 0; i < 65536; i++)
      begin
         ref_mem[i] = {fill_byte({i[15:0], 1'b1}), fill_byte({i[15:0], 1'b0})};
         written[i] = 1'b0;
      end
      for (int i = 0; i < (1 << `COPRO_EXT_AW); i++)
         sram[i] = fill_byte(i[16:0]);

      repeat (10) @(posedge cpu_clk);
      @(negedge cpu_clk);
      rst_n = 1'b1;
      @(negedge cpu_clk);

      // reset state
      check_val("clken", {15'h0000, clken}, 16'h0001);
      check_val("irq_b", {15'h0000, irq_b}, 16'h0001);
      check_val("rd_stb", {15'h0000, rd_stb}, 16'h0000);
      check_val("ram strobes", {13'h0000, ram_cs_b, ram_oe_b, ram_we_b}, 16'h0007);
      check_val("h_status", {14'h0000, h_status}, 16'h0000);

      // internal ram random access with gaps
      for (int n = 0; n < 60; n++)
      begin
         a  = int_addr();
         rd = coin();
         if (!written[a])
            rd = 1'b0;
         r = rand_bits(16);
         issue(rd, a, r[15:0]);
         if (coin() && coin())
            bus_idle();
      end
      // back-to-back burst over both windows
      for (int n = 0; n < 8; n++)
      begin
         r = rand_bits(16);
         issue(1'b0, (n < 4) ? 16'h0100 + 16'(n) : 16'hF100 + 16'(n), r[15:0]);
      end
      for (int n = 0; n < 8; n++)
         issue(1'b1, (n < 4) ? 16'h0100 + 16'(n) : 16'hF100 + 16'(n), 16'h0000);
      drain();

      // external sram with variable latency
      check_lat = 1'b0;
      for (int n = 0; n < 40; n++)
      begin
         a  = ext_addr();
         rd = coin();
         r  = rand_bits(16);
         issue(rd, a, r[15:0]);
      end
      drain();
      // low byte lives at the even address
      foreach (ext_wr_q[i])
      begin
         a = ext_wr_q[i];
         check_val("sram even byte", {8'h00, sram[{a, 1'b0}]}, {8'h00, ref_mem[a][7:0]});
         check_val("sram odd byte", {8'h00, sram[{a, 1'b1}]}, {8'h00, ref_mem[a][15:8]});
      end

      // host to coprocessor
      check_lat = 1'b1;
      check_host_pins();
      host_write(8'hA5);
      check_host_pins();
      host_write(8'h3C);
      check_host_pins();
      issue(1'b1, 16'hFEF8, 16'h0000);
      issue(1'b1, 16'hFEF9, 16'h0000);
      issue(1'b1, 16'hFEF8, 16'h0000);
      drain();
      check_host_pins();

      // coprocessor to host
      issue(1'b0, 16'hFEFA, 16'h005A);
      drain();
      check_host_pins();
      issue(1'b0, 16'hFEFA, 16'h00C3);
      issue(1'b1, 16'hFEF8, 16'h0000);
      issue(1'b1, 16'hFEFA, 16'h0000);
      drain();
      check_host_pins();
      host_read();
      check_host_pins();
      // unused offsets
      for (int n = 3; n < 8; n++)
      begin
         r = rand_bits(16);
         issue(1'b0, 16'hFEF8 + 16'(n), r[15:0]);
         issue(1'b1, 16'hFEF8 + 16'(n), 16'h0000);
      end
      drain();
      check_host_pins();

      // mix across all regions with in-order return
      check_lat = 1'b0;
      for (int n = 0; n < 80; n++)
      begin
         r = rand_bits(2);
         if (r[1:0] == 2'd1)
            a = ext_addr();
         else if (r[1:0] == 2'd2)
         begin
            r = rand_bits(3);
            a = 16'hFEF8 + {13'h0000, r[2:0]};
         end
         else
            a = int_addr();
         rd = coin();
         if ((region_of(a) == copro_bus_pkg::REG_INT) && !written[a])
            rd = 1'b0;
         r = rand_bits(16);
         issue(rd, a, r[15:0]);
      end
      drain();
      check_host_pins();

      if (dut_i.props_i.fail_count == 0)
      begin
         $display("Result: PASSED");
         $finish;
      end
      else
         fail_run("bound bus and sram assertions reported errors");
   end

endmodule

// File: tb.f
+incdir+rtl
rtl/copro_bus_pkg.sv
rtl/copro_mem_pkg.sv
rtl/copro_stage_if.sv
rtl/int_word_ram.sv
rtl/host_mailbox.sv
rtl/ext_mem_ctrl.sv
rtl/addr_decode_stage.sv
rtl/access_stage.sv
rtl/copro_bus.sv
tests/copro_props.sv
tests/copro_tb.sv

// File: Bender.yml
package:
  name: copro_bus

sources:
  # design sources, packages first
  - include_dirs:
      - rtl
    files:
      - rtl/copro_bus_pkg.sv
      - rtl/copro_mem_pkg.sv
      - rtl/copro_stage_if.sv
      - rtl/int_word_ram.sv
      - rtl/host_mailbox.sv
      - rtl/ext_mem_ctrl.sv
      - rtl/addr_decode_stage.sv
      - rtl/access_stage.sv
      - rtl/copro_bus.sv

  # testbench and bound assertions
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/copro_props.sv
      - tests/copro_tb.sv
